// ==== source/id_pkg.sv ====
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] pc_t;                  // word addressed

    localparam reg_addr_t LINK_REG = 5'd31;
    localparam reg_addr_t ZERO_REG = 5'd0;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL function codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // REGIMM rt codes
    localparam reg_addr_t RT_BLTZ   = 5'h00;
    localparam reg_addr_t RT_BGEZ   = 5'h01;
    localparam reg_addr_t RT_BLTZAL = 5'h10;
    localparam reg_addr_t RT_BGEZAL = 5'h11;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_JR, ALU_JALR
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_JUMP_BRANCH
    } alusel_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_ZERO, IMM_SIGN, IMM_UPPER, IMM_SHAMT
    } imm_kind_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JUMP_FIELD, BR_JUMP_REG, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
    } br_kind_e;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] fn;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } inst_i_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target26;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_j_t j;
    } inst_u;

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        logic      re1;
        logic      re2;
        logic      we;
        reg_addr_t waddr;
        imm_kind_e imm_kind;
        br_kind_e  br_kind;
        logic      link;
    } ctrl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        logic taken;
        pc_t  target;
    } branch_req_t;

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     op1;
        word_t     op2;
        logic      we;
        reg_addr_t waddr;
        word_t     link_addr;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== source/decode_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl (
    input  id_pkg::inst_u     inst_i,
    output id_pkg::ctrl_t     ctrl_o,
    output id_pkg::reg_addr_t raddr1_o,
    output id_pkg::reg_addr_t raddr2_o
);
    import id_pkg::*;

    always_comb begin
        ctrl_o = '0;                            // inactive, no write
        ctrl_o.waddr = inst_i.r.rd;
        case (inst_i.r.op)
            OP_SPECIAL: begin
                case (inst_i.r.fn)
                    FN_AND:  ctrl_o.aluop = ALU_AND;
                    FN_OR:   ctrl_o.aluop = ALU_OR;
                    FN_XOR:  ctrl_o.aluop = ALU_XOR;
                    FN_NOR:  ctrl_o.aluop = ALU_NOR;
                    FN_SLL,
                    FN_SLLV: ctrl_o.aluop = ALU_SLL;
                    FN_SRL,
                    FN_SRLV: ctrl_o.aluop = ALU_SRL;
                    FN_SRA,
                    FN_SRAV: ctrl_o.aluop = ALU_SRA;
                    FN_ADD:  ctrl_o.aluop = ALU_ADD;
                    FN_ADDU: ctrl_o.aluop = ALU_ADDU;
                    FN_SUB:  ctrl_o.aluop = ALU_SUB;
                    FN_SUBU: ctrl_o.aluop = ALU_SUBU;
                    FN_SLT:  ctrl_o.aluop = ALU_SLT;
                    FN_SLTU: ctrl_o.aluop = ALU_SLTU;
                    FN_JR:   ctrl_o.aluop = ALU_JR;
                    FN_JALR: ctrl_o.aluop = ALU_JALR;
                    default: ctrl_o.aluop = ALU_NOP;
                endcase
                if (ctrl_o.aluop != ALU_NOP) begin
                    ctrl_o.re1 = 1'b1;
                    ctrl_o.re2 = 1'b1;
                    ctrl_o.we = 1'b1;
                end
                case (inst_i.r.fn)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        ctrl_o.re1 = 1'b0;          // op1 takes shamt
                        ctrl_o.imm_kind = IMM_SHAMT;
                    end
                    FN_JR: begin
                        ctrl_o.we = 1'b0;
                        ctrl_o.re2 = 1'b0;
                        ctrl_o.br_kind = BR_JUMP_REG;
                    end
                    FN_JALR: begin
                        ctrl_o.re2 = 1'b0;
                        ctrl_o.link = 1'b1;
                        ctrl_o.br_kind = BR_JUMP_REG;
                        if (inst_i.r.rd == ZERO_REG) ctrl_o.waddr = LINK_REG;
                    end
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                case (inst_i.i.rt)
                    RT_BLTZ:   ctrl_o.br_kind = BR_LTZ;
                    RT_BGEZ:   ctrl_o.br_kind = BR_GEZ;
                    RT_BLTZAL: ctrl_o.br_kind = BR_LTZ;
                    RT_BGEZAL: ctrl_o.br_kind = BR_GEZ;
                    default:   ctrl_o.br_kind = BR_NONE;
                endcase
                ctrl_o.re1 = (ctrl_o.br_kind != BR_NONE);
                ctrl_o.aluop = ctrl_o.re1 ? ALU_JR : ALU_NOP;
                if (inst_i.i.rt == RT_BLTZAL || inst_i.i.rt == RT_BGEZAL) begin
                    ctrl_o.aluop = ALU_JALR;
                    ctrl_o.we = 1'b1;
                    ctrl_o.link = 1'b1;
                    ctrl_o.waddr = LINK_REG;
                end
            end
            OP_J, OP_JAL: begin
                ctrl_o.aluop = ALU_JR;
                ctrl_o.br_kind = BR_JUMP_FIELD;
                if (inst_i.j.op == OP_JAL) begin
                    ctrl_o.aluop = ALU_JALR;
                    ctrl_o.we = 1'b1;
                    ctrl_o.link = 1'b1;
                    ctrl_o.waddr = LINK_REG;
                end
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                ctrl_o.aluop = ALU_JR;
                ctrl_o.re1 = 1'b1;
                ctrl_o.re2 = (inst_i.i.op == OP_BEQ || inst_i.i.op == OP_BNE);
                case (inst_i.i.op)
                    OP_BEQ:  ctrl_o.br_kind = BR_EQ;
                    OP_BNE:  ctrl_o.br_kind = BR_NE;
                    OP_BLEZ: ctrl_o.br_kind = BR_LEZ;
                    default: ctrl_o.br_kind = BR_GTZ;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl_o.we = 1'b1;
                ctrl_o.waddr = inst_i.i.rt;             // immediates write rt
                ctrl_o.re1 = (inst_i.i.op != OP_LUI);
                case (inst_i.i.op)
                    OP_ADDI:  ctrl_o.aluop = ALU_ADD;
                    OP_ADDIU: ctrl_o.aluop = ALU_ADDU;
                    OP_SLTI:  ctrl_o.aluop = ALU_SLT;
                    OP_SLTIU: ctrl_o.aluop = ALU_SLTU;
                    OP_ANDI:  ctrl_o.aluop = ALU_AND;
                    OP_XORI:  ctrl_o.aluop = ALU_XOR;
                    default:  ctrl_o.aluop = ALU_OR;    // ori and lui
                endcase
                case (inst_i.i.op)
                    OP_ANDI, OP_ORI, OP_XORI: ctrl_o.imm_kind = IMM_ZERO;
                    OP_LUI:                   ctrl_o.imm_kind = IMM_UPPER;
                    default:                  ctrl_o.imm_kind = IMM_SIGN;
                endcase
            end
            default: ;
        endcase
        case (ctrl_o.aluop)
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: ctrl_o.alusel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         ctrl_o.alusel = SEL_SHIFT;
            ALU_JR, ALU_JALR:                  ctrl_o.alusel = SEL_JUMP_BRANCH;
            ALU_NOP:                           ctrl_o.alusel = SEL_NOP;
            default:                           ctrl_o.alusel = SEL_ARITH;
        endcase
    end

    assign raddr1_o = ctrl_o.re1 ? inst_i.r.rs : ZERO_REG;
    assign raddr2_o = ctrl_o.re2 ? inst_i.r.rt : ZERO_REG;

endmodule

`default_nettype wire

// ==== source/operand_fwd.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_fwd (
    input  logic              re_i,
    input  id_pkg::reg_addr_t raddr_i,
    input  id_pkg::fwd_t      ex_fwd_i,
    input  id_pkg::fwd_t      mem_fwd_i,
    input  id_pkg::word_t     rdata_i,
    input  id_pkg::inst_u     inst_i,
    input  id_pkg::imm_kind_e imm_kind_i,
    output id_pkg::word_t     op_o
);
    import id_pkg::*;

    word_t imm;

    always_comb begin
        case (imm_kind_i)
            IMM_ZERO:  imm = {16'h0000, inst_i.i.imm16};
            IMM_SIGN:  imm = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
            IMM_UPPER: imm = {inst_i.i.imm16, 16'h0000};     // lui
            IMM_SHAMT: imm = {27'd0, inst_i.r.sa};
            default:   imm = '0;
        endcase
    end

    always_comb begin
        if (!re_i)
            op_o = imm;
        else if (ex_fwd_i.we && ex_fwd_i.waddr == raddr_i)
            op_o = ex_fwd_i.wdata;                      // youngest result wins
        else if (mem_fwd_i.we && mem_fwd_i.waddr == raddr_i)
            op_o = mem_fwd_i.wdata;
        else
            op_o = rdata_i;
    end

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  id_pkg::br_kind_e    br_kind_i,
    input  logic                link_i,
    input  id_pkg::word_t       op1_i,
    input  id_pkg::word_t       op2_i,
    input  id_pkg::pc_t         pc_i,
    input  id_pkg::inst_u       inst_i,
    output id_pkg::branch_req_t req_o,
    output id_pkg::word_t       link_addr_o
);
    import id_pkg::*;

    logic  op1_zero;
    logic  taken;
    pc_t   offset;
    pc_t   target;

    assign op1_zero = (op1_i == '0);
    assign offset = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};

    always_comb begin
        case (br_kind_i)
            BR_JUMP_FIELD,
            BR_JUMP_REG: taken = 1'b1;
            BR_EQ:       taken = (op1_i == op2_i);
            BR_NE:       taken = (op1_i != op2_i);
            BR_LEZ:      taken = op1_i[31] || op1_zero;
            BR_GTZ:      taken = !op1_i[31] && !op1_zero;
            BR_LTZ:      taken = op1_i[31];
            BR_GEZ:      taken = !op1_i[31];
            default:     taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind_i)
            BR_JUMP_FIELD: target = {6'd0, inst_i.j.target26};
            BR_JUMP_REG:   target = op1_i;
            default:       target = pc_i + offset;     // pc relative
        endcase
    end

    assign req_o.taken = taken;
    assign req_o.target = taken ? target : '0;
    assign link_addr_o = link_i ? pc_i + 32'd1 : '0;

endmodule

`default_nettype wire

// ==== source/id_ex_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                valid_i,
    input  id_pkg::id_ex_t      id_ex_i,
    input  id_pkg::branch_req_t branch_i,
    output id_pkg::id_ex_t      id_ex_o,
    output id_pkg::branch_req_t branch_o,
    output logic                ex_valid_o
);
    import id_pkg::*;

    logic        valid_q;
    logic        we_q;
    logic        taken_q;
    aluop_e      aluop_q;
    id_ex_t      id_ex_q;
    branch_req_t branch_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            we_q <= 1'b0;
            taken_q <= 1'b0;
            aluop_q <= ALU_NOP;
        end else if (!stall_i) begin                // hold while stalled
            valid_q <= valid_i;
            we_q <= valid_i && id_ex_i.we;
            taken_q <= valid_i && branch_i.taken;
            aluop_q <= valid_i ? id_ex_i.aluop : ALU_NOP;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && !stall_i) begin
            id_ex_q <= id_ex_i;
            branch_q <= branch_i;
        end
    end

    always_comb begin
        id_ex_o = id_ex_q;
        id_ex_o.aluop = aluop_q;
        id_ex_o.we = we_q;
        branch_o = branch_q;
        branch_o.taken = taken_q;
    end

    assign ex_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== source/id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                inst_valid_i,
    input  id_pkg::pc_t         pc_i,
    input  id_pkg::inst_u       inst_i,
    input  id_pkg::word_t       rdata1_i,
    input  id_pkg::word_t       rdata2_i,
    input  id_pkg::fwd_t        ex_fwd_i,
    input  id_pkg::fwd_t        mem_fwd_i,
    output id_pkg::reg_addr_t   raddr1_o,
    output id_pkg::reg_addr_t   raddr2_o,
    output logic                re1_o,
    output logic                re2_o,
    output id_pkg::id_ex_t      id_ex_o,
    output id_pkg::branch_req_t branch_o,
    output logic                ex_valid_o
);
    import id_pkg::*;

    ctrl_t       ctrl;
    word_t       op1;
    word_t       op2;
    word_t       link_addr;
    branch_req_t branch_d;
    id_ex_t      id_ex_d;

    assign re1_o = ctrl.re1;
    assign re2_o = ctrl.re2;

    decode_ctrl u_decode_ctrl (
        .inst_i   (inst_i),
        .ctrl_o   (ctrl),
        .raddr1_o (raddr1_o),
        .raddr2_o (raddr2_o)
    );

    operand_fwd u_operand1 (
        .re_i       (ctrl.re1),
        .raddr_i    (raddr1_o),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .rdata_i    (rdata1_i),
        .inst_i     (inst_i),
        .imm_kind_i (ctrl.imm_kind),
        .op_o       (op1)
    );

    operand_fwd u_operand2 (
        .re_i       (ctrl.re2),
        .raddr_i    (raddr2_o),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .rdata_i    (rdata2_i),
        .inst_i     (inst_i),
        .imm_kind_i (ctrl.imm_kind),
        .op_o       (op2)
    );

    branch_unit u_branch_unit (
        .br_kind_i   (ctrl.br_kind),
        .link_i      (ctrl.link),
        .op1_i       (op1),
        .op2_i       (op2),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .req_o       (branch_d),
        .link_addr_o (link_addr)
    );

    assign id_ex_d = '{aluop: ctrl.aluop, alusel: ctrl.alusel, op1: op1, op2: op2,
                       we: ctrl.we, waddr: ctrl.waddr, link_addr: link_addr};

    id_ex_reg u_id_ex_reg (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall_i),
        .valid_i    (inst_valid_i),
        .id_ex_i    (id_ex_d),
        .branch_i   (branch_d),
        .id_ex_o    (id_ex_o),
        .branch_o   (branch_o),
        .ex_valid_o (ex_valid_o)
    );

endmodule

`default_nettype wire

// ==== sim/id_stage_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage_asserts (
    input logic                clk_i,
    input logic                rst_i,
    input logic                stall_i,
    input logic                inst_valid_i,
    input id_pkg::id_ex_t      id_ex_o,
    input id_pkg::branch_req_t branch_o,
    input logic                ex_valid_o
);
    import id_pkg::*;

    reset_idle: assert property (@(posedge clk_i)
        rst_i |=> !ex_valid_o && !id_ex_o.we && !branch_o.taken && id_ex_o.aluop == ALU_NOP)
        else $error("outputs active after reset");

    stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> $stable(id_ex_o) && $stable(branch_o) && $stable(ex_valid_o))
        else $error("outputs changed while stalled");

    // an empty cycle leaves nothing for execute
    empty_slot: assert property (@(posedge clk_i) disable iff (rst_i)
        !inst_valid_i && !stall_i |=> !ex_valid_o && !id_ex_o.we && !branch_o.taken)
        else $error("outputs active after a cycle without valid");

endmodule

bind id_stage id_stage_asserts u_id_stage_asserts (.*);

`default_nettype wire

// ==== sim/tb_id_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    localparam int N_STEPS = 400;
    localparam int N_OPS = 37;
    localparam int TIMEOUT_NS = (N_STEPS * 3 + 50) * 8;   // at most 3 cycles per step

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     op1;
        word_t     op2;
        logic      we;
        reg_addr_t waddr;
        word_t     link_addr;
        logic      taken;
        pc_t       target;
        logic      re1;
        logic      re2;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
    } exp_t;

    logic        clk_i;
    logic        rst_i;
    logic        stall_i;
    logic        inst_valid_i;
    pc_t         pc_i;
    inst_u       inst_i;
    word_t       rdata1_i;
    word_t       rdata2_i;
    fwd_t        ex_fwd_i;
    fwd_t        mem_fwd_i;
    reg_addr_t   raddr1_o;
    reg_addr_t   raddr2_o;
    logic        re1_o;
    logic        re2_o;
    id_ex_t      id_ex_o;
    branch_req_t branch_o;
    logic        ex_valid_o;

    logic [31:0] seed;
    logic        chk_q;
    exp_t        exp_q;
    logic        re1_q;
    logic        re2_q;
    reg_addr_t   raddr1_q;
    reg_addr_t   raddr2_q;
    logic [11:0] op_list [N_OPS];           // {op, fn or rt}

    id_stage u_id_stage (.*);

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic word_t pick(input logic re, input reg_addr_t a, input fwd_t ex,
                                   input fwd_t mem, input word_t rdata, input word_t imm);
        if (!re)
            return imm;
        if (ex.we && ex.waddr == a)
            return ex.wdata;
        if (mem.we && mem.waddr == a)
            return mem.wdata;
        return rdata;
    endfunction

    // expected stage output for one instruction
    function automatic exp_t model(input inst_u in, input pc_t pc, input fwd_t ex,
                                   input fwd_t mem, input word_t rd1, input word_t rd2);
        exp_t  e;
        logic  re1;
        logic  re2;
        logic  link;
        word_t imm;
        int    kind;                        // 1 jfield 2 jreg 3 eq 4 ne 5 lez 6 gtz 7 ltz 8 gez
        e = '0;
        re1 = 1'b0;
        re2 = 1'b0;
        link = 1'b0;
        imm = '0;
        kind = 0;
        e.aluop = ALU_NOP;
        e.alusel = SEL_NOP;
        e.waddr = in.r.rd;
        case (in.r.op)
            OP_SPECIAL: begin
                re1 = 1'b1;
                re2 = 1'b1;
                e.we = 1'b1;
                e.alusel = SEL_ARITH;
                case (in.r.fn)
                    FN_AND: begin e.aluop = ALU_AND; e.alusel = SEL_LOGIC; end
                    FN_OR:  begin e.aluop = ALU_OR;  e.alusel = SEL_LOGIC; end
                    FN_XOR: begin e.aluop = ALU_XOR; e.alusel = SEL_LOGIC; end
                    FN_NOR: begin e.aluop = ALU_NOR; e.alusel = SEL_LOGIC; end
                    FN_SLL, FN_SLLV: begin e.aluop = ALU_SLL; e.alusel = SEL_SHIFT; end
                    FN_SRL, FN_SRLV: begin e.aluop = ALU_SRL; e.alusel = SEL_SHIFT; end
                    FN_SRA, FN_SRAV: begin e.aluop = ALU_SRA; e.alusel = SEL_SHIFT; end
                    FN_ADD:  e.aluop = ALU_ADD;
                    FN_ADDU: e.aluop = ALU_ADDU;
                    FN_SUB:  e.aluop = ALU_SUB;
                    FN_SUBU: e.aluop = ALU_SUBU;
                    FN_SLT:  e.aluop = ALU_SLT;
                    FN_SLTU: e.aluop = ALU_SLTU;
                    FN_JR: begin
                        e.aluop = ALU_JR;
                        e.alusel = SEL_JUMP_BRANCH;
                        e.we = 1'b0;
                        re2 = 1'b0;
                        kind = 2;
                    end
                    FN_JALR: begin
                        e.aluop = ALU_JALR;
                        e.alusel = SEL_JUMP_BRANCH;
                        re2 = 1'b0;
                        link = 1'b1;
                        kind = 2;
                        e.waddr = (in.r.rd == ZERO_REG) ? LINK_REG : in.r.rd;
                    end
                    default: begin
                        e.alusel = SEL_NOP;
                        e.we = 1'b0;
                        re1 = 1'b0;
                        re2 = 1'b0;
                    end
                endcase
                if (in.r.fn == FN_SLL || in.r.fn == FN_SRL || in.r.fn == FN_SRA) begin
                    re1 = 1'b0;             // shift amount from sa field
                    imm = {27'd0, in.r.sa};
                end
            end
            OP_REGIMM: begin
                if (in.i.rt == RT_BLTZ || in.i.rt == RT_BGEZ ||
                    in.i.rt == RT_BLTZAL || in.i.rt == RT_BGEZAL) begin
                    re1 = 1'b1;
                    e.aluop = ALU_JR;
                    e.alusel = SEL_JUMP_BRANCH;
                    kind = (in.i.rt == RT_BLTZ || in.i.rt == RT_BLTZAL) ? 7 : 8;
                    if (in.i.rt[4]) begin
                        e.aluop = ALU_JALR;
                        e.we = 1'b1;
                        link = 1'b1;
                        e.waddr = LINK_REG;
                    end
                end
            end
            OP_J, OP_JAL: begin
                e.aluop = (in.r.op == OP_JAL) ? ALU_JALR : ALU_JR;
                e.alusel = SEL_JUMP_BRANCH;
                kind = 1;
                if (in.r.op == OP_JAL) begin
                    e.we = 1'b1;
                    link = 1'b1;
                    e.waddr = LINK_REG;
                end
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                e.aluop = ALU_JR;
                e.alusel = SEL_JUMP_BRANCH;
                re1 = 1'b1;
                re2 = (in.r.op == OP_BEQ || in.r.op == OP_BNE);
                kind = int'(in.r.op) - int'(OP_BEQ) + 3;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                e.we = 1'b1;
                e.waddr = in.i.rt;
                re1 = (in.r.op != OP_LUI);
                imm = {{16{in.i.imm16[15]}}, in.i.imm16};
                e.alusel = SEL_ARITH;
                case (in.r.op)
                    OP_ADDI:  e.aluop = ALU_ADD;
                    OP_ADDIU: e.aluop = ALU_ADDU;
                    OP_SLTI:  e.aluop = ALU_SLT;
                    OP_SLTIU: e.aluop = ALU_SLTU;
                    default: begin
                        e.alusel = SEL_LOGIC;
                        imm = {16'h0000, in.i.imm16};
                        e.aluop = (in.r.op == OP_ANDI) ? ALU_AND :
                                  (in.r.op == OP_XORI) ? ALU_XOR : ALU_OR;
                    end
                endcase
                if (in.r.op == OP_LUI)
                    imm = {in.i.imm16, 16'h0000};
            end
            default: ;
        endcase
        e.re1 = re1;
        e.re2 = re2;
        e.raddr1 = in.r.rs;
        e.raddr2 = in.r.rt;
        e.op1 = pick(re1, in.r.rs, ex, mem, rd1, imm);
        e.op2 = pick(re2, in.r.rt, ex, mem, rd2, imm);
        case (kind)
            1, 2:    e.taken = 1'b1;
            3:       e.taken = (e.op1 == e.op2);
            4:       e.taken = (e.op1 != e.op2);
            5:       e.taken = $signed(e.op1) <= 0;
            6:       e.taken = $signed(e.op1) > 0;
            7:       e.taken = $signed(e.op1) < 0;
            8:       e.taken = $signed(e.op1) >= 0;
            default: e.taken = 1'b0;
        endcase
        if (kind == 1)
            e.target = {6'd0, in.j.target26};
        else if (kind == 2)
            e.target = e.op1;
        else
            e.target = pc + {{16{in.i.imm16[15]}}, in.i.imm16};
        e.link_addr = link ? pc + 32'd1 : '0;
        return e;
    endfunction

    task automatic mismatch(input string name, input logic [31:0] e, input logic [31:0] a);
        $display("ERROR %s expected %h actual %h", name, e, a);
        $display("Checks failed");
        $fatal(1, "output mismatch");
    endtask

    // expectation of the sample taken at this edge, checked at the next one
    always @(posedge clk_i) begin
        chk_q <= inst_valid_i && !stall_i && !rst_i;
        exp_q <= model(inst_i, pc_i, ex_fwd_i, mem_fwd_i, rdata1_i, rdata2_i);
        re1_q <= re1_o;                     // read port is combinational
        re2_q <= re2_o;
        raddr1_q <= raddr1_o;
        raddr2_q <= raddr2_o;
    end

    assert property (@(posedge clk_i) disable iff (rst_i) chk_q |-> ex_valid_o)
        else mismatch("ex_valid_o", 32'd1, 32'($sampled(ex_valid_o)));
    assert property (@(posedge clk_i) disable iff (rst_i) chk_q |-> id_ex_o.aluop == exp_q.aluop)
        else mismatch("id_ex_o.aluop", 32'($sampled(exp_q.aluop)), 32'($sampled(id_ex_o.aluop)));
    assert property (@(posedge clk_i) disable iff (rst_i)
        chk_q |-> id_ex_o.alusel == exp_q.alusel)
        else mismatch("id_ex_o.alusel", 32'($sampled(exp_q.alusel)),
                      32'($sampled(id_ex_o.alusel)));
    assert property (@(posedge clk_i) disable iff (rst_i) chk_q |-> id_ex_o.op1 == exp_q.op1)
        else mismatch("id_ex_o.op1", $sampled(exp_q.op1), $sampled(id_ex_o.op1));
    assert property (@(posedge clk_i) disable iff (rst_i) chk_q |-> id_ex_o.op2 == exp_q.op2)
        else mismatch("id_ex_o.op2", $sampled(exp_q.op2), $sampled(id_ex_o.op2));
    assert property (@(posedge clk_i) disable iff (rst_i) chk_q |-> id_ex_o.we == exp_q.we)
        else mismatch("id_ex_o.we", 32'($sampled(exp_q.we)), 32'($sampled(id_ex_o.we)));
    assert property (@(posedge clk_i) disable iff (rst_i)
        chk_q && exp_q.we |-> id_ex_o.waddr == exp_q.waddr)
        else mismatch("id_ex_o.waddr", 32'($sampled(exp_q.waddr)),
                      32'($sampled(id_ex_o.waddr)));
    assert property (@(posedge clk_i) disable iff (rst_i)
        chk_q |-> id_ex_o.link_addr == exp_q.link_addr)
        else mismatch("id_ex_o.link_addr", $sampled(exp_q.link_addr),
                      $sampled(id_ex_o.link_addr));
    assert property (@(posedge clk_i) disable iff (rst_i)
        chk_q |-> branch_o.taken == exp_q.taken)
        else mismatch("branch_o.taken", 32'($sampled(exp_q.taken)),
                      32'($sampled(branch_o.taken)));
    assert property (@(posedge clk_i) disable iff (rst_i)
        chk_q && exp_q.taken |-> branch_o.target == exp_q.target)
        else mismatch("branch_o.target", $sampled(exp_q.target), $sampled(branch_o.target));
    assert property (@(posedge clk_i) disable iff (rst_i) chk_q |-> re1_q == exp_q.re1)
        else mismatch("re1_o", 32'($sampled(exp_q.re1)), 32'($sampled(re1_q)));
    assert property (@(posedge clk_i) disable iff (rst_i) chk_q |-> re2_q == exp_q.re2)
        else mismatch("re2_o", 32'($sampled(exp_q.re2)), 32'($sampled(re2_q)));
    assert property (@(posedge clk_i) disable iff (rst_i)
        chk_q && exp_q.re1 |-> raddr1_q == exp_q.raddr1)
        else mismatch("raddr1_o", 32'($sampled(exp_q.raddr1)), 32'($sampled(raddr1_q)));
    assert property (@(posedge clk_i) disable iff (rst_i)
        chk_q && exp_q.re2 |-> raddr2_q == exp_q.raddr2)
        else mismatch("raddr2_o", 32'($sampled(exp_q.raddr2)), 32'($sampled(raddr2_q)));

    // small value set so BEQ/BNE and sign tests hit both outcomes
    function automatic word_t rand_data();
        seed = xorshift(seed);
        case (seed[1:0])
            2'd0:    return '0;
            2'd1:    return 32'h0000_0005;
            2'd2:    return 32'hffff_fff0;
            default: return seed;
        endcase
    endfunction

    task automatic drive_random(input int step);
        inst_u in;
        seed = xorshift(seed);
        in = seed;
        in.r.op = op_list[step % N_OPS][11:6];
        if (in.r.op == OP_SPECIAL)
            in.r.fn = op_list[step % N_OPS][5:0];
        else if (in.r.op == OP_REGIMM)
            in.i.rt = op_list[step % N_OPS][4:0];
        else if (in.r.op != OP_J && in.r.op != OP_JAL)
            in.i.rt = {3'd0, seed[24:23]};
        if (in.r.op != OP_J && in.r.op != OP_JAL) begin
            in.r.rs = {3'd0, seed[22:21]};          // few registers, many matches
            if (in.r.op == OP_SPECIAL) begin
                in.r.rt = {3'd0, seed[26:25]};
                in.r.rd = {3'd0, seed[28:27]};
            end
        end
        inst_i = in;
        inst_valid_i = (seed[31:29] != 3'd0);
        seed = xorshift(seed);
        pc_i = seed;
        rdata1_i = rand_data();
        rdata2_i = rand_data();
        seed = xorshift(seed);
        ex_fwd_i = '{we: seed[0], waddr: {3'd0, seed[2:1]}, wdata: rand_data()};
        seed = xorshift(seed);
        mem_fwd_i = '{we: seed[0], waddr: {3'd0, seed[2:1]}, wdata: rand_data()};
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "watchdog expired before the stimulus finished");
    end

    initial begin
        int stall_n;
        op_list = '{
            {OP_SPECIAL, FN_AND}, {OP_SPECIAL, FN_OR}, {OP_SPECIAL, FN_XOR},
            {OP_SPECIAL, FN_NOR}, {OP_SPECIAL, FN_SLL}, {OP_SPECIAL, FN_SRL},
            {OP_SPECIAL, FN_SRA}, {OP_SPECIAL, FN_SLLV}, {OP_SPECIAL, FN_SRLV},
            {OP_SPECIAL, FN_SRAV}, {OP_SPECIAL, FN_JR}, {OP_SPECIAL, FN_JALR},
            {OP_SPECIAL, FN_ADD}, {OP_SPECIAL, FN_ADDU}, {OP_SPECIAL, FN_SUB},
            {OP_SPECIAL, FN_SUBU}, {OP_SPECIAL, FN_SLT}, {OP_SPECIAL, FN_SLTU},
            {OP_REGIMM, 1'b0, RT_BLTZ}, {OP_REGIMM, 1'b0, RT_BGEZ},
            {OP_REGIMM, 1'b0, RT_BLTZAL}, {OP_REGIMM, 1'b0, RT_BGEZAL},
            {OP_J, 6'h00}, {OP_JAL, 6'h00}, {OP_BEQ, 6'h00}, {OP_BNE, 6'h00},
            {OP_BLEZ, 6'h00}, {OP_BGTZ, 6'h00}, {OP_ADDI, 6'h00}, {OP_ADDIU, 6'h00},
            {OP_SLTI, 6'h00}, {OP_SLTIU, 6'h00}, {OP_ANDI, 6'h00}, {OP_ORI, 6'h00},
            {OP_XORI, 6'h00}, {OP_LUI, 6'h00}, {6'h3f, 6'h00}   // last one undefined
        };
        seed = 32'd31225;
        rst_i = 1'b1;
        stall_i = 1'b0;
        inst_valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        rdata1_i = '0;
        rdata2_i = '0;
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);
        for (int step = 0; step < N_STEPS; step++) begin
            @(negedge clk_i);
            drive_random(step);
            seed = xorshift(seed);
            stall_n = (step > 4 && seed[2:0] == 3'd0) ? 1 + int'(seed[3]) : 0;
            if (stall_n > 0) begin
                stall_i = 1'b1;             // inputs held until the stall drops
                repeat (stall_n) @(negedge clk_i);
                stall_i = 1'b0;
            end
        end
        @(negedge clk_i);
        inst_valid_i = 1'b0;
        repeat (3) @(posedge clk_i);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/id_pkg.sv
source/decode_ctrl.sv
source/operand_fwd.sv
source/branch_unit.sv
source/id_ex_reg.sv
source/id_stage.sv
sim/id_stage_asserts.sv
sim/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_id_stage
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
